/* compile.f */
+incdir+rtl
+incdir+testbench
rtl/decodePkg.sv
rtl/opcodeMatch.sv
rtl/decodeLane.sv
rtl/laneDispatch.sv
rtl/resultCollector.sv
rtl/instrDecoder.sv
testbench/tbInstrDecoder.sv

/* rtl/decodeLane.sv */
`default_nettype none

module decodeLane (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   load,
  input  decodePkg::instrBytes   instr,
  input  logic                   drain,
  output logic                   full,
  output decodePkg::decodeResult result
);
  import decodePkg::*;

  decodeResult matchResult;

  opcodeMatch opcodeMatch_inst (
    .instr  (instr),
    .result (matchResult)
  );

  //////////////////////////////////////////////////
  // slot occupancy
  //////////////////////////////////////////////////
  // dispatch only loads a free lane, so load and drain never meet here
  always_ff @(posedge clk) begin
    if (reset) begin
      full <= 1'b0;
    end else if (load) begin
      full <= 1'b1;
    end else if (drain) begin
      full <= 1'b0;
    end
  end

  // decoded word is held until the collector takes it
  always_ff @(posedge clk) begin
    if (load) begin
      result <= matchResult;
    end
  end

endmodule

`default_nettype wire

/* rtl/decodePkg.sv */
`default_nettype none

package decodePkg;

  //////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////
  localparam int NUM_LANES   = 4;  // also the upstream credit count
  localparam int LANE_IDX_W  = $clog2(NUM_LANES);
  localparam int NUM_ENTRIES = 24;
  localparam int ENTRY_IDX_W = 5;
  localparam int CREDIT_W    = 4;

  //////////////////////////////////////////////////
  // payload types
  //////////////////////////////////////////////////
  typedef struct packed {
    logic [7:0] opcode;
    logic [7:0] modrm;
    logic [7:0] seqTag;  // opaque, travels with the instruction
  } instrBytes;

  typedef struct packed {
    logic [4:0]  aluOp;
    logic [2:0]  srcSel;
    logic [2:0]  dstSel;
    logic [1:0]  immSize;
    logic        hasModrm;
    logic        memRead;
    logic        memWrite;
    logic        regWrite;
    logic        flagsWrite;
    logic        isBranch;
    logic        isStack;
    logic [11:0] uopId;
  } ctrlWord;

  typedef struct packed {
    logic [7:0] opcode;
    logic [2:0] regField;
    logic       useReg;  // compare modrm[5:3] as well
    ctrlWord    ctrl;
  } matchEntry;

  typedef struct packed {
    logic [7:0]             seqTag;
    logic                   illegal;
    logic [ENTRY_IDX_W-1:0] entryIdx;
    ctrlWord                ctrl;
    logic [7:0]             opcode;
    logic [2:0]             regField;
  } decodeResult;

  // flags go hasModrm, memRead, memWrite, regWrite, flagsWrite, isBranch, isStack
  function automatic ctrlWord mkCtrl(
    input logic [4:0]  aluOp,
    input logic [2:0]  srcSel,
    input logic [2:0]  dstSel,
    input logic [1:0]  immSize,
    input logic [6:0]  flags,
    input logic [11:0] uopId
  );
    return {aluOp, srcSel, dstSel, immSize, flags, uopId};
  endfunction

  `include "opcodeTable.svh"

endpackage

`default_nettype wire

/* rtl/instrDecoder.sv */
`default_nettype none

module instrDecoder (
  input  logic                   clk,
  input  logic                   reset,
  input  decodePkg::instrBytes   inInstr,
  input  logic                   inValid,
  output logic                   inCredit,
  output decodePkg::decodeResult outResult,
  output logic                   outValid,
  input  logic                   outCredit
);
  import decodePkg::*;

  logic [NUM_LANES-1:0] laneLoad;
  logic [NUM_LANES-1:0] laneFull;
  logic [NUM_LANES-1:0] laneDrain;
  instrBytes            laneInstr;
  decodeResult          laneResult [NUM_LANES];

  //////////////////////////////////////////////////
  // dispatch
  //////////////////////////////////////////////////
  laneDispatch laneDispatch_inst (
    .clk       (clk),
    .reset     (reset),
    .inInstr   (inInstr),
    .inValid   (inValid),
    .laneLoad  (laneLoad),
    .laneInstr (laneInstr)
  );

  //////////////////////////////////////////////////
  // decode lanes, one per in-flight slot
  //////////////////////////////////////////////////
  for (genvar g = 0; g < NUM_LANES; g++) begin : genLane
    decodeLane decodeLane_inst (
      .clk    (clk),
      .reset  (reset),
      .load   (laneLoad[g]),
      .instr  (laneInstr),
      .drain  (laneDrain[g]),
      .full   (laneFull[g]),
      .result (laneResult[g])
    );
  end

  //////////////////////////////////////////////////
  // in-order collection
  //////////////////////////////////////////////////
  resultCollector resultCollector_inst (
    .clk        (clk),
    .reset      (reset),
    .laneFull   (laneFull),
    .laneResult (laneResult),
    .outCredit  (outCredit),
    .laneDrain  (laneDrain),
    .outResult  (outResult),
    .outValid   (outValid),
    .inCredit   (inCredit)
  );

endmodule

`default_nettype wire

/* rtl/laneDispatch.sv */
`default_nettype none

module laneDispatch (
  input  logic                             clk,
  input  logic                             reset,
  input  decodePkg::instrBytes             inInstr,
  input  logic                             inValid,
  output logic [decodePkg::NUM_LANES-1:0]  laneLoad,
  output decodePkg::instrBytes             laneInstr
);
  import decodePkg::*;

  logic [LANE_IDX_W-1:0] wrPtr;

  //////////////////////////////////////////////////
  // round robin write pointer
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
    end else if (inValid) begin
      wrPtr <= wrPtr + 1'b1;  // wraps, lane count is a power of two
    end
  end

  // upstream credits keep the pointed lane free
  assign laneLoad  = inValid ? (NUM_LANES'(1) << wrPtr) : '0;
  assign laneInstr = inInstr;  // shared by all lanes, only the loaded one captures

endmodule

`default_nettype wire

/* rtl/opcodeMatch.sv */
`default_nettype none

module opcodeMatch (
  input  decodePkg::instrBytes   instr,
  output decodePkg::decodeResult result
);
  import decodePkg::*;

  logic [NUM_ENTRIES-1:0] hit;
  logic [2:0]             regField;
  logic                   anyHit;
  logic [ENTRY_IDX_W-1:0] hitIdx;
  ctrlWord                selCtrl;

  assign regField = instr.modrm[5:3];  // reg field of ModRM

  //////////////////////////////////////////////////
  // one comparator per table entry
  //////////////////////////////////////////////////
  for (genvar e = 0; e < NUM_ENTRIES; e++) begin : genHit
    assign hit[e] = (instr.opcode == OPCODE_TABLE[e].opcode) &&
                    (!OPCODE_TABLE[e].useReg || (OPCODE_TABLE[e].regField == regField));
  end

  //////////////////////////////////////////////////
  // priority select, lowest index wins
  //////////////////////////////////////////////////
  always_comb begin
    anyHit  = 1'b0;
    hitIdx  = '1;
    selCtrl = '0;
    // walk downward so the lowest hit is written last
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (hit[i]) begin
        anyHit  = 1'b1;
        hitIdx  = ENTRY_IDX_W'(i);
        selCtrl = OPCODE_TABLE[i].ctrl;
      end
    end
  end

  always_comb begin
    result.seqTag   = instr.seqTag;
    result.illegal  = !anyHit;
    result.entryIdx = hitIdx;   // all ones when nothing hits
    result.ctrl     = selCtrl;  // zero when nothing hits
    result.opcode   = instr.opcode;
    result.regField = regField;
  end

endmodule

`default_nettype wire

/* rtl/opcodeTable.svh */
`ifndef OPCODE_TABLE_SVH
`define OPCODE_TABLE_SVH

//////////////////////////////////////////////////
// control store match table, lowest index wins
//////////////////////////////////////////////////
// sel codes: 0 none, 1 reg, 2 rm, 3 imm, 4 mem, 5 pc, 6 stack
// imm codes: 0 none, 1 byte, 2 dword
localparam matchEntry OPCODE_TABLE [NUM_ENTRIES] = '{
  '{8'h50, 3'd0, 1'b0, mkCtrl(5'h00, 3'd1, 3'd6, 2'd0, 7'b0010001, 12'h010)}, // push eAX
  '{8'h53, 3'd0, 1'b0, mkCtrl(5'h00, 3'd1, 3'd6, 2'd0, 7'b0010001, 12'h011)}, // push eBX
  '{8'h58, 3'd0, 1'b0, mkCtrl(5'h00, 3'd6, 3'd1, 2'd0, 7'b0101001, 12'h012)}, // pop eAX
  '{8'h5B, 3'd0, 1'b0, mkCtrl(5'h00, 3'd6, 3'd1, 2'd0, 7'b0101001, 12'h013)}, // pop eBX
  '{8'h74, 3'd0, 1'b0, mkCtrl(5'h07, 3'd5, 3'd5, 2'd1, 7'b0000010, 12'h020)}, // jz rel8
  '{8'h75, 3'd0, 1'b0, mkCtrl(5'h07, 3'd5, 3'd5, 2'd1, 7'b0000010, 12'h021)}, // jnz rel8
  '{8'h7C, 3'd0, 1'b0, mkCtrl(5'h07, 3'd5, 3'd5, 2'd1, 7'b0000010, 12'h022)}, // jl rel8
  '{8'hB8, 3'd0, 1'b0, mkCtrl(5'h00, 3'd3, 3'd1, 2'd2, 7'b0001000, 12'h030)}, // mov eAX, imm32
  '{8'hB0, 3'd0, 1'b0, mkCtrl(5'h00, 3'd3, 3'd1, 2'd1, 7'b0001000, 12'h031)}, // mov AL, imm8
  '{8'h0F, 3'd0, 1'b0, mkCtrl(5'h00, 3'd0, 3'd0, 2'd0, 7'b0000000, 12'h040)}, // two byte escape
  '{8'h80, 3'd0, 1'b1, mkCtrl(5'h01, 3'd3, 3'd2, 2'd1, 7'b1001100, 12'h050)}, // add rm8, imm8
  '{8'h80, 3'd4, 1'b1, mkCtrl(5'h03, 3'd3, 3'd2, 2'd1, 7'b1001100, 12'h051)}, // and rm8, imm8
  '{8'h81, 3'd0, 1'b1, mkCtrl(5'h01, 3'd3, 3'd2, 2'd2, 7'b1001100, 12'h052)}, // add rm, imm32
  '{8'h81, 3'd5, 1'b1, mkCtrl(5'h02, 3'd3, 3'd2, 2'd2, 7'b1001100, 12'h053)}, // sub rm, imm32
  '{8'h83, 3'd7, 1'b1, mkCtrl(5'h04, 3'd3, 3'd2, 2'd1, 7'b1000100, 12'h054)}, // cmp rm, imm8
  '{8'h0F, 3'd0, 1'b0, mkCtrl(5'h00, 3'd0, 3'd0, 2'd0, 7'b0000000, 12'h041)}, // shadowed by 9
  '{8'hFF, 3'd2, 1'b1, mkCtrl(5'h00, 3'd2, 3'd5, 2'd0, 7'b1010011, 12'h060)}, // call rm
  '{8'hFF, 3'd4, 1'b1, mkCtrl(5'h00, 3'd2, 3'd5, 2'd0, 7'b1000010, 12'h061)}, // jmp rm
  '{8'hFF, 3'd6, 1'b1, mkCtrl(5'h00, 3'd2, 3'd6, 2'd0, 7'b1010001, 12'h062)}, // push rm
  '{8'hD1, 3'd4, 1'b1, mkCtrl(5'h05, 3'd2, 3'd2, 2'd0, 7'b1001100, 12'h070)}, // shl rm, 1
  '{8'hD1, 3'd7, 1'b1, mkCtrl(5'h06, 3'd2, 3'd2, 2'd0, 7'b1001100, 12'h071)}, // sar rm, 1
  '{8'hC3, 3'd0, 1'b0, mkCtrl(5'h00, 3'd6, 3'd5, 2'd0, 7'b0100011, 12'h080)}, // ret
  '{8'hE8, 3'd0, 1'b0, mkCtrl(5'h00, 3'd5, 3'd5, 2'd2, 7'b0010011, 12'h081)}, // call rel32
  '{8'hE9, 3'd0, 1'b0, mkCtrl(5'h00, 3'd5, 3'd5, 2'd2, 7'b0000010, 12'h082)}  // jmp rel32
};

`endif

/* rtl/resultCollector.sv */
`default_nettype none

module resultCollector (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [decodePkg::NUM_LANES-1:0] laneFull,
  input  decodePkg::decodeResult          laneResult [decodePkg::NUM_LANES],
  input  logic                            outCredit,
  output logic [decodePkg::NUM_LANES-1:0] laneDrain,
  output decodePkg::decodeResult          outResult,
  output logic                            outValid,
  output logic                            inCredit
);
  import decodePkg::*;

  logic [LANE_IDX_W-1:0] rdPtr;
  logic [CREDIT_W-1:0]   creditCnt;
  logic                  send;

  //////////////////////////////////////////////////
  // drain decision
  //////////////////////////////////////////////////
  assign send      = laneFull[rdPtr] && (creditCnt != '0);
  assign laneDrain = send ? (NUM_LANES'(1) << rdPtr) : '0;

  // read pointer follows the dispatch order, keeping results in program order
  always_ff @(posedge clk) begin
    if (reset) begin
      rdPtr <= '0;
    end else if (send) begin
      rdPtr <= rdPtr + 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // downstream credits
  //////////////////////////////////////////////////
  // grant and spend can land in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      creditCnt <= '0;
    end else begin
      creditCnt <= creditCnt + CREDIT_W'(outCredit) - CREDIT_W'(send);
    end
  end

  //////////////////////////////////////////////////
  // output stage
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
      inCredit <= 1'b0;
    end else begin
      outValid <= send;
      inCredit <= send;  // freed lane goes back upstream
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      outResult <= laneResult[rdPtr];
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# builds the instruction decoder testbench with Verilator and runs it
# exit status is nonzero when the log reports a failure

cd "$(dirname "$0")" || exit 1

logFile=sim.log
rm -f "$logFile"

verilator --binary -j 0 -f compile.f --top-module tbInstrDecoder -o tbInstrDecoder \
  && ./obj_dir/tbInstrDecoder > "$logFile" 2>&1 \
  || { cat "$logFile" 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat "$logFile"

grep -q "Result: FAILED" "$logFile" && { echo "simulation reported errors"; exit 1; }
grep -q "Result: PASSED" "$logFile" || { echo "no result line found in $logFile"; exit 1; }

echo "simulation finished cleanly"
exit 0

/* testbench/decodeTests.svh */
`ifndef DECODE_TESTS_SVH
`define DECODE_TESTS_SVH

//////////////////////////////////////////////////
// credit handshake out of reset
//////////////////////////////////////////////////
task automatic creditHandshake();
  int errBefore;
  errBefore = errorCount;
  stepCycles(5);
  checkEq(64'(resultCount), 64'(0), "outValid seen right after reset");
  checkEq(64'(inCreditCount), 64'(0), "inCredit seen right after reset");
  sendInstr(8'h50, 8'h00);
  stepCycles(20);  // decoder holds no downstream credit yet
  checkEq(64'(resultCount), 64'(0), "result sent without downstream credit");
  outCredit = 1'b1;
  grantCount++;
  stepCycles(1);
  outCredit = 1'b0;
  drainAll();
  stepCycles(3);
  checkEq(64'(resultCount), 64'(1), "results after one credit");
  checkEq(64'(inCreditCount), 64'(1), "inCredit pulses after one result");
  checkEq(64'(freeCredits()), 64'(NUM_LANES), "upstream credits restored");
  reportTest("credit handshake", errBefore);
endtask

// every entry without a reg compare, 0F always lands on the first copy
task automatic plainOpcodes();
  int errBefore;
  int expIdx;
  errBefore = errorCount;
  for (int e = 0; e < NUM_ENTRIES; e++) begin
    if (!OPCODE_TABLE[e].useReg) begin
      decodeOne(OPCODE_TABLE[e].opcode, randBits(8));
      expIdx = (OPCODE_TABLE[e].opcode == 8'h0F) ? 9 : e;
      checkEq(64'(lastResult.illegal), 64'(0),
              $sformatf("illegal flag of opcode %h", OPCODE_TABLE[e].opcode));
      checkEq(64'(lastResult.entryIdx), 64'(expIdx),
              $sformatf("entry index of opcode %h", OPCODE_TABLE[e].opcode));
      checkEq(64'(lastResult.ctrl), 64'(OPCODE_TABLE[expIdx].ctrl),
              $sformatf("control word of opcode %h", OPCODE_TABLE[e].opcode));
    end
  end
  repeat (4) begin
    decodeOne(8'h0F, randBits(8));
    checkEq(64'(lastResult.entryIdx), 64'(9), "0F entry index");
  end
  reportTest("plain opcodes", errBefore);
endtask

//////////////////////////////////////////////////
// group opcodes, selected by ModRM reg
//////////////////////////////////////////////////
task automatic groupOpcodes();
  logic [7:0] groups [5];
  int         errBefore;
  groups = '{8'h80, 8'h81, 8'h83, 8'hFF, 8'hD1};
  errBefore = errorCount;
  foreach (groups[g]) begin
    for (int r = 0; r < 8; r++) begin
      decodeOne(groups[g], {2'b01, 3'(r), 3'(randBits(3))});  // monitor compares
    end
  end
  decodeOne(8'h80, {2'b11, 3'd0, 3'b001});
  checkEq(64'(lastResult.entryIdx), 64'(10), "80 reg 0 entry index");
  checkEq(64'(lastResult.ctrl), 64'(OPCODE_TABLE[10].ctrl), "80 reg 0 control word");
  decodeOne(8'h80, {2'b11, 3'd4, 3'b001});
  checkEq(64'(lastResult.entryIdx), 64'(11), "80 reg 4 entry index");
  checkEq(64'(lastResult.ctrl), 64'(OPCODE_TABLE[11].ctrl), "80 reg 4 control word");
  decodeOne(8'h80, {2'b11, 3'd3, 3'b001});
  checkEq(64'(lastResult.illegal), 64'(1), "80 reg 3 illegal flag");
  reportTest("group opcodes", errBefore);
endtask

task automatic illegalOpcodes();
  logic [7:0] absent [6];
  int         errBefore;
  absent = '{8'h00, 8'h0E, 8'h51, 8'h90, 8'hCC, 8'hFE};
  errBefore = errorCount;
  foreach (absent[i]) begin
    decodeOne(absent[i], randBits(8));
    checkEq(64'(lastResult.illegal), 64'(1), $sformatf("illegal flag of %h", absent[i]));
    checkEq(64'(lastResult.ctrl), 64'(0), $sformatf("control word of %h", absent[i]));
    checkEq(64'(lastResult.entryIdx), 64'(5'h1F), $sformatf("entry index of %h", absent[i]));
  end
  reportTest("illegal opcodes", errBefore);
endtask

//////////////////////////////////////////////////
// back-pressure and random stream
//////////////////////////////////////////////////
task automatic backPressure();
  int errBefore;
  int resBefore;
  int crBefore;
  errBefore = errorCount;
  resBefore = resultCount;
  crBefore  = inCreditCount;
  for (int i = 0; i < NUM_LANES; i++) begin
    sendInstr(OPCODE_TABLE[i * 5].opcode, randBits(8));
  end
  checkEq(64'(freeCredits()), 64'(0), "upstream credits with all lanes loaded");
  stepCycles(20);
  checkEq(64'(resultCount - resBefore), 64'(0), "results while downstream is stalled");
  checkEq(64'(inCreditCount - crBefore), 64'(0), "inCredit while downstream is stalled");
  drainAll();
  stepCycles(2);
  checkEq(64'(resultCount - resBefore), 64'(NUM_LANES), "results released");
  checkEq(64'(inCreditCount - crBefore), 64'(NUM_LANES), "inCredit pulses released");
  reportTest("back-pressure", errBefore);
endtask

task automatic randomStream();
  logic [7:0] streamOp [STREAM_LEN];
  logic [7:0] streamModrm [STREAM_LEN];
  logic       coin;
  int         errBefore;
  int         target;
  int         grants;
  int         waitCycles;
  errBefore = errorCount;
  for (int i = 0; i < STREAM_LEN; i++) begin
    if (randBits(2) == 8'd0) begin
      streamOp[i] = randBits(8);  // any byte, mostly illegal
    end else begin
      streamOp[i] = OPCODE_TABLE[int'(randBits(5)) % NUM_ENTRIES].opcode;
    end
    streamModrm[i] = randBits(8);
  end
  target     = resultCount + STREAM_LEN;
  grants     = 0;
  waitCycles = 0;
  fork
    begin
      for (int i = 0; i < STREAM_LEN; i++) begin
        sendInstr(streamOp[i], streamModrm[i]);
      end
    end
    begin
      while (resultCount < target && waitCycles < STREAM_LEN * 40) begin
        coin = randBits(1) == 8'd1;
        // keep the 4 bit credit counter far from wrapping
        outCredit = coin && (grants < STREAM_LEN) && (grantCount - resultCount < 8);
        if (outCredit) begin
          grants++;
          grantCount++;
        end
        stepCycles(1);
        waitCycles++;
      end
      outCredit = 1'b0;
    end
  join
  if (resultCount < target) begin
    $display("timeout: random stream ended with %0d results missing", target - resultCount);
    errorCount++;
  end
  stepCycles(3);
  checkEq(64'(resultCount), 64'(target), "results of the random stream");
  checkEq(64'(inCreditCount), 64'(resultCount), "one inCredit pulse per result");
  reportTest("random stream", errBefore);
endtask

`endif

/* testbench/tbInstrDecoder.sv */
`default_nettype none

module tbInstrDecoder;
  import decodePkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int STREAM_LEN     = 200;

  logic        clk;
  logic        reset;
  instrBytes   inInstr;
  logic        inValid;
  logic        inCredit;
  decodeResult outResult;
  logic        outValid;
  logic        outCredit;

  decodeResult expTable [256];  // expected result by seqTag
  decodeResult lastResult;
  logic [31:0] lfsrState;
  int          sentCount;       // instructions handed to the DUT
  int          resultCount;     // results seen on outValid
  int          inCreditCount;
  int          grantCount;      // outCredit pulses given
  int          errorCount;
  int          checkCount;
  int          testCount;

  instrDecoder instrDecoder_inst (
    .clk       (clk),
    .reset     (reset),
    .inInstr   (inInstr),
    .inValid   (inValid),
    .inCredit  (inCredit),
    .outResult (outResult),
    .outValid  (outValid),
    .outCredit (outCredit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // random bits and reference model
  //////////////////////////////////////////////////
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // taps 32 22 2 1
  endfunction

  function automatic logic [7:0] randBits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[6:0], lfsrState[0]};
    end
    return v;
  endfunction

  // first table entry whose opcode and, if asked, reg field agree
  function automatic decodeResult refDecode(input instrBytes ins);
    decodeResult r;
    r.seqTag   = ins.seqTag;
    r.illegal  = 1'b1;
    r.entryIdx = '1;
    r.ctrl     = '0;
    r.opcode   = ins.opcode;
    r.regField = ins.modrm[5:3];
    for (int e = 0; e < NUM_ENTRIES; e++) begin
      if (r.illegal && OPCODE_TABLE[e].opcode == ins.opcode &&
          (!OPCODE_TABLE[e].useReg || OPCODE_TABLE[e].regField == ins.modrm[5:3])) begin
        r.illegal  = 1'b0;
        r.entryIdx = ENTRY_IDX_W'(e);
        r.ctrl     = OPCODE_TABLE[e].ctrl;
      end
    end
    return r;
  endfunction

  function automatic int freeCredits();
    return NUM_LANES + inCreditCount - sentCount;
  endfunction

  //////////////////////////////////////////////////
  // checking and reporting
  //////////////////////////////////////////////////
  task automatic checkEq(input logic [63:0] got, input logic [63:0] exp, input string what);
    checkCount++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, what, got, exp);
      errorCount++;
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testCount++;
    if (errorCount == errBefore) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errorCount - errBefore);
    end
  endtask

  task automatic stepCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // outputs are sampled mid cycle, away from the clock edge
  task automatic watchOutputs();
    decodeResult expected;
    forever begin
      @(negedge clk);
      if (inCredit) inCreditCount++;
      if (outValid) begin
        if (resultCount >= sentCount) begin
          $display("unexpected result at %0t: no instruction was pending", $time);
          errorCount++;
        end else begin
          expected = expTable[resultCount % 256];
          checkEq(64'(outResult), 64'(expected),
                  $sformatf("result for tag %0d", expected.seqTag));
        end
        lastResult = outResult;
        resultCount++;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // upstream and downstream credit handling
  //////////////////////////////////////////////////
  task automatic sendInstr(input logic [7:0] opcode, input logic [7:0] modrm);
    instrBytes ins;
    int        waitCycles;
    waitCycles = 0;
    while (freeCredits() == 0 && waitCycles < TIMEOUT_CYCLES) begin
      stepCycles(1);
      waitCycles++;
    end
    if (freeCredits() == 0) begin
      $display("timeout: no upstream credit came back to send opcode %h", opcode);
      errorCount++;
    end else begin
      ins.opcode = opcode;
      ins.modrm  = modrm;
      ins.seqTag = 8'(sentCount);
      expTable[sentCount % 256] = refDecode(ins);
      inInstr = ins;
      inValid = 1'b1;
      sentCount++;
      stepCycles(1);
      inValid = 1'b0;
    end
  endtask

  // one grant per instruction sent, then wait for every result
  task automatic drainAll();
    int waitCycles;
    waitCycles = 0;
    while (resultCount < sentCount && waitCycles < TIMEOUT_CYCLES) begin
      outCredit = grantCount < sentCount;
      if (outCredit) grantCount++;
      stepCycles(1);
      waitCycles++;
    end
    outCredit = 1'b0;
    if (resultCount < sentCount) begin
      $display("timeout: %0d results still missing after granting credits",
               sentCount - resultCount);
      errorCount++;
    end
  endtask

  task automatic decodeOne(input logic [7:0] opcode, input logic [7:0] modrm);
    sendInstr(opcode, modrm);
    drainAll();
  endtask

  `include "decodeTests.svh"

  initial begin
    reset         = 1'b1;
    inInstr       = '0;
    inValid       = 1'b0;
    outCredit     = 1'b0;
    lfsrState     = 32'h2bd1_d1ca;
    sentCount     = 0;
    resultCount   = 0;
    inCreditCount = 0;
    grantCount    = 0;
    errorCount    = 0;
    checkCount    = 0;
    testCount     = 0;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    fork
      watchOutputs();
    join_none
    creditHandshake();
    plainOpcodes();
    groupOpcodes();
    illegalOpcodes();
    backPressure();
    randomStream();
    $display("done: %0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
